// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps
TOP        := mem_subsystem_tb
FILELIST   := compile.f
PASS_MSG   := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+include
design/mem_pkg.sv
design/word_ram.sv
design/unaligned_access_ctrl.sv
design/mem_port_arbiter.sv
design/mem_subsystem_top.sv
testbench/mem_subsystem_asserts.sv
testbench/mem_subsystem_tb.sv

// File: design/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

    typedef struct packed {
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;   // byte address
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_DATA_W-1:0] wmask;  // bit mask, 1 takes new bit
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] rdata;
        logic                   valid;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        wait_cmd       = 2'd0,
        wait_mem_ready = 2'd1,
        wait_mem_read  = 2'd2
    } arb_state_t;

endpackage

// File: design/mem_port_arbiter.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_port_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_start,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    output logic                   inst_ready,
    output logic                   inst_valid,
    output logic [`MEM_DATA_W-1:0] inst,
    input  logic                   d_start,
    input  mem_pkg::mem_req_t      d_req,
    output logic                   d_ready,
    output logic                   rdata_valid,
    output logic [`MEM_DATA_W-1:0] rdata,
    output logic                   cmd_start,
    output mem_pkg::mem_req_t      cmd,
    input  logic                   cmd_ready,
    input  mem_pkg::mem_rsp_t      rsp
);
    import mem_pkg::*;

    arb_state_t             state;
    logic                   cmd_is_inst;    // command in flight is a fetch
    logic                   d_pending;      // data command waits behind fetch
    logic [`MEM_ADDR_W-1:0] save_i_addr;
    mem_req_t               save_d_req;
    logic [`MEM_DATA_W-1:0] inst_q;
    logic [`MEM_DATA_W-1:0] rdata_q;
    logic                   inst_done;
    logic                   data_done;
    logic                   issue_pending;

    function automatic mem_req_t fetch_req(input logic [`MEM_ADDR_W-1:0] addr);
        mem_req_t r;
        r = '0;
        r.addr = addr;
        return r;
    endfunction

    assign inst_ready = (state == wait_cmd);
    assign d_ready    = inst_ready;           // one shared ready

    assign inst_done     = (state == wait_mem_read) && rsp.valid && cmd_is_inst;
    assign data_done     = (state == wait_mem_read) && rsp.valid && !cmd_is_inst;
    assign issue_pending = inst_done && d_pending;

    assign inst_valid  = inst_done;
    assign rdata_valid = data_done;
    assign inst        = inst_done ? rsp.rdata : inst_q;
    assign rdata       = data_done ? rsp.rdata : rdata_q;

    always_comb begin
        cmd_start = 1'b0;
        cmd       = save_d_req;
        case (state)
            wait_cmd: begin
                cmd_start = cmd_ready && (inst_start || d_start);
                cmd       = inst_start ? fetch_req(i_addr) : d_req;  // fetch first
            end
            wait_mem_ready: begin
                cmd_start = 1'b1;                 // held until taken
                cmd       = cmd_is_inst ? fetch_req(save_i_addr) : save_d_req;
            end
            wait_mem_read: begin
                cmd_start = issue_pending && cmd_ready;
            end
            default: begin
                cmd_start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= wait_cmd;
            cmd_is_inst <= 1'b0;
            d_pending   <= 1'b0;
        end else begin
            case (state)
                wait_cmd: begin
                    if (inst_start || d_start) begin
                        cmd_is_inst <= inst_start;
                        d_pending   <= inst_start && d_start;
                        if (!cmd_ready) begin
                            state <= wait_mem_ready;
                        end else if (!inst_start && d_req.write) begin
                            state <= wait_cmd;      // writes return nothing
                        end else begin
                            state <= wait_mem_read;
                        end
                    end
                end
                wait_mem_ready: begin
                    if (cmd_ready) begin
                        if (!cmd_is_inst && save_d_req.write) begin
                            state <= wait_cmd;
                        end else begin
                            state <= wait_mem_read;
                        end
                    end
                end
                wait_mem_read: begin
                    if (issue_pending) begin
                        cmd_is_inst <= 1'b0;        // data command goes next
                        d_pending   <= 1'b0;
                        if (!cmd_ready) begin
                            state <= wait_mem_ready;
                        end else if (save_d_req.write) begin
                            state <= wait_cmd;
                        end else begin
                            state <= wait_mem_read;
                        end
                    end else if (rsp.valid) begin
                        state <= wait_cmd;
                    end
                end
                default: begin
                    state <= wait_cmd;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wait_cmd && inst_start) begin
            save_i_addr <= i_addr;
        end
        if (state == wait_cmd && d_start) begin
            save_d_req <= d_req;
        end
        if (inst_done) begin
            inst_q <= rsp.rdata;
        end
        if (data_done) begin
            rdata_q <= rsp.rdata;
        end
    end

endmodule

// File: design/mem_subsystem_top.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_subsystem_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_start,
    output logic                   inst_ready,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    output logic [`MEM_DATA_W-1:0] inst,
    output logic                   inst_valid,
    input  logic                   d_start,
    output logic                   d_ready,
    input  mem_pkg::mem_req_t      d_req,
    output logic [`MEM_DATA_W-1:0] rdata,
    output logic                   rdata_valid
);
    import mem_pkg::*;

    logic                          cmd_start;
    logic                          cmd_ready;
    mem_req_t                      cmd;
    mem_rsp_t                      rsp;
    logic                          ram_we;
    logic [$clog2(`MEM_WORDS)-1:0] ram_addr;
    logic [`MEM_DATA_W-1:0]        ram_wdata;
    logic [`MEM_DATA_W-1:0]        ram_rdata;

    mem_port_arbiter mem_port_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_start  (inst_start),
        .i_addr      (i_addr),
        .inst_ready  (inst_ready),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .d_start     (d_start),
        .d_req       (d_req),
        .d_ready     (d_ready),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .cmd_start   (cmd_start),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .rsp         (rsp)
    );

    unaligned_access_ctrl unaligned_access_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    word_ram word_ram_i (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// File: design/unaligned_access_ctrl.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module unaligned_access_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_start,
    input  mem_pkg::mem_req_t             cmd,
    output logic                          cmd_ready,
    output mem_pkg::mem_rsp_t             rsp,
    output logic                          ram_we,
    output logic [$clog2(`MEM_WORDS)-1:0] ram_addr,
    output logic [`MEM_DATA_W-1:0]        ram_wdata,
    input  logic [`MEM_DATA_W-1:0]        ram_rdata
);
    import mem_pkg::*;

    typedef enum logic [2:0] {
        c_idle,
        c_rd0,      // address first word
        c_rd1,      // address second word, capture first
        c_resp,
        c_wr_rd,    // read word for merge
        c_wr_wb     // write merged word back
    } ctrl_state_t;

    ctrl_state_t                     state;
    mem_req_t                        req_q;
    logic                            hi_q;      // working on the upper word
    logic [`MEM_DATA_W-1:0]          lo_q;
    logic [1:0]                      off;
    logic                            unaligned;
    logic [5:0]                      shamt;
    logic [$clog2(`MEM_WORDS)-1:0]   base;
    logic [2*`MEM_DATA_W-1:0]        wide_data;
    logic [2*`MEM_DATA_W-1:0]        wide_mask;
    logic [2*`MEM_DATA_W-1:0]        joined;
    logic [`MEM_DATA_W-1:0]          word_data;
    logic [`MEM_DATA_W-1:0]          word_mask;
    logic                            use_hi;

    assign off       = req_q.addr[1:0];
    assign unaligned = (off != 2'd0);
    assign shamt     = {1'b0, off, 3'b000};
    assign base      = req_q.addr[2 +: $clog2(`MEM_WORDS)];  // wraps at depth

    // little-endian: byte offset shifts data toward the upper word
    assign wide_data = {{`MEM_DATA_W{1'b0}}, req_q.wdata} << shamt;
    assign wide_mask = {{`MEM_DATA_W{1'b0}}, req_q.wmask} << shamt;
    assign word_data = hi_q ? wide_data[2*`MEM_DATA_W-1:`MEM_DATA_W] : wide_data[`MEM_DATA_W-1:0];
    assign word_mask = hi_q ? wide_mask[2*`MEM_DATA_W-1:`MEM_DATA_W] : wide_mask[`MEM_DATA_W-1:0];

    assign use_hi    = (state == c_rd1) || ((state == c_wr_rd || state == c_wr_wb) && hi_q);
    assign ram_addr  = use_hi ? base + 1'b1 : base;
    assign ram_we    = (state == c_wr_wb);
    assign ram_wdata = (ram_rdata & ~word_mask) | (word_data & word_mask);

    assign joined    = {ram_rdata, lo_q} >> shamt;
    assign cmd_ready = (state == c_idle) || (state == c_resp);

    always_comb begin
        rsp.valid = (state == c_resp);
        rsp.rdata = unaligned ? joined[`MEM_DATA_W-1:0] : ram_rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= c_idle;
            hi_q  <= 1'b0;
        end else begin
            case (state)
                c_idle, c_resp: begin
                    if (cmd_start) begin
                        hi_q  <= 1'b0;
                        state <= cmd.write ? c_wr_rd : c_rd0;
                    end else begin
                        state <= c_idle;
                    end
                end
                c_rd0: begin
                    state <= unaligned ? c_rd1 : c_resp;
                end
                c_rd1: begin
                    state <= c_resp;
                end
                c_wr_rd: begin
                    state <= c_wr_wb;
                end
                c_wr_wb: begin
                    if (unaligned && !hi_q) begin
                        hi_q  <= 1'b1;          // second word next
                        state <= c_wr_rd;
                    end else begin
                        state <= c_idle;
                    end
                end
                default: begin
                    state <= c_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start && cmd_ready) begin
            req_q <= cmd;
        end
        if (state == c_rd1) begin
            lo_q <= ram_rdata;
        end
    end

endmodule

// File: design/word_ram.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module word_ram (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(`MEM_WORDS)-1:0] addr,
    input  logic [`MEM_DATA_W-1:0]        wdata,
    output logic [`MEM_DATA_W-1:0]        rdata
);

    logic [`MEM_DATA_W-1:0] mem [`MEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];     // old word on a write cycle
    end

endmodule

// File: include/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data and write mask width
`define MEM_DATA_W 32
// byte address width
`define MEM_ADDR_W 32
// RAM depth in words, 4 KiB
`define MEM_WORDS 1024

`endif

// File: testbench/mem_cases.txt
# columns: name op addr addr2 wdata wmask expected expected2, numbers in hex
# op is write, read, fetch or both (fetch at addr and data read at addr2)
w0 write 00000000 0 11223344 ffffffff 0 0
w4 write 00000004 0 55667788 ffffffff 0 0
w8 write 00000008 0 99aabbcc ffffffff 0 0
wc write 0000000c 0 ddeeff00 ffffffff 0 0
w10 write 00000010 0 a0a1a2a3 ffffffff 0 0
w14 write 00000014 0 b0b1b2b3 ffffffff 0 0
rd_w0 read 00000000 0 0 0 11223344 0
fe_w4 fetch 00000004 0 0 0 55667788 0
mask_wr write 0000000c 0 12345678 0f0f00ff 0 0
mask_rd read 0000000c 0 0 0 d2e4ff78 0
ua_rd1 read 00000001 0 0 0 88112233 0
ua_fe2 fetch 00000002 0 0 0 77881122 0
ua_rd3 read 00000003 0 0 0 66778811 0
ua_wr1 write 00000011 0 cafef00d ffffffff 0 0
ua_rd11 read 00000011 0 0 0 cafef00d 0
ua_hi14 read 00000014 0 0 0 b0b1b2ca 0
ua_wr3 write 0000000f 0 13579bdf ffffffff 0 0
ua_rd0f read 0000000f 0 0 0 13579bdf 0
ua_lo0c read 0000000c 0 0 0 dfe4ff78 0
ua_hi10 fetch 00000010 0 0 0 fe13579b 0
both_rd both 00000000 00000010 0 0 11223344 fe13579b
wrap_rd read 00001000 0 0 0 11223344 0
wrap_wr write 00001028 0 600dcafe ffffffff 0 0
wrap_fe fetch 00000028 0 0 0 600dcafe 0
ua_wr2 write 00000006 0 5a5aa5a5 00ffff00 0 0
ua_rd6 read 00000006 0 0 0 bb5aa566 0
ua_lo4 fetch 00000004 0 0 0 a5667788 0
ua_hi8 read 00002008 0 0 0 99aabb5a 0

// File: testbench/mem_subsystem_asserts.sv
`timescale 1ns/1ps

module mem_subsystem_asserts (
    input logic                clk,
    input logic                rst_n,
    input mem_pkg::arb_state_t state,
    input logic                d_pending,
    input logic                inst_valid,
    input logic                rdata_valid,
    input logic                cmd_start,
    input logic                cmd_ready,
    input mem_pkg::mem_req_t   cmd,
    input mem_pkg::mem_rsp_t   rsp
);
    import mem_pkg::*;

    int failures = 0;   // failed assertions so far

    // each response lands on exactly one port
    rsp_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid |-> (inst_valid != rdata_valid))
        else begin
            $error("response not steered to exactly one port");
            failures++;
        end

    // stalled command must not move
    cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_start && !cmd_ready) |=> $stable(cmd))
        else begin
            $error("cmd changed while cmd_ready was low");
            failures++;
        end

    // ports open only once the stored data command has gone out
    no_pending_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == wait_cmd) |-> !d_pending)
        else begin
            $error("data command still pending in wait_cmd");
            failures++;
        end

endmodule

// File: testbench/mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_subsystem_tb;
    import mem_pkg::*;

    localparam int TIMEOUT = 40;    // cycles per wait

    logic                   clk;
    logic                   rst_n;
    logic                   inst_start;
    logic                   inst_ready;
    logic [`MEM_ADDR_W-1:0] i_addr;
    logic [`MEM_DATA_W-1:0] inst;
    logic                   inst_valid;
    logic                   d_start;
    logic                   d_ready;
    mem_req_t               d_req;
    logic [`MEM_DATA_W-1:0] rdata;
    logic                   rdata_valid;
    int                     errors;
    int                     timeouts;

    mem_subsystem_top mem_subsystem_top_i (.*);

    bind mem_port_arbiter mem_subsystem_asserts mem_subsystem_asserts_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .d_pending   (d_pending),
        .inst_valid  (inst_valid),
        .rdata_valid (rdata_valid),
        .cmd_start   (cmd_start),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd),
        .rsp         (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input logic [127:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_ready(input logic [127:0] name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(inst_ready && d_ready) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!(inst_ready && d_ready)) begin
            $display("timeout in case %0s: ports never became ready", name);
            timeouts++;
        end
    endtask

    task automatic start_cmd(input logic fetch, input logic data,
                             input logic [31:0] f_addr, input mem_req_t req);
        @(posedge clk);
        inst_start <= fetch;
        d_start    <= data;
        i_addr     <= f_addr;
        d_req      <= req;
        @(posedge clk);
        inst_start <= 1'b0;
        d_start    <= 1'b0;
    endtask

    // waits for the wanted valid pulses and checks data and order
    task automatic collect_results(input logic [127:0] name, input logic want_inst,
                                   input logic want_data, input logic [31:0] exp_inst,
                                   input logic [31:0] exp_data);
        int cycle;
        int inst_at;
        int data_at;
        cycle   = 0;
        inst_at = -1;
        data_at = -1;
        while (((want_inst && inst_at < 0) || (want_data && data_at < 0))
               && cycle < TIMEOUT) begin
            @(negedge clk);
            cycle++;
            if (inst_valid) begin
                if (!want_inst || inst_at >= 0) begin
                    $display("case %0s got an unexpected inst_valid pulse", name);
                    errors++;
                end
                inst_at = cycle;
                check_value(name, exp_inst, inst);
            end
            if (rdata_valid) begin
                if (!want_data || data_at >= 0) begin
                    $display("case %0s got an unexpected rdata_valid pulse", name);
                    errors++;
                end
                data_at = cycle;
                check_value(name, exp_data, rdata);
            end
        end
        if ((want_inst && inst_at < 0) || (want_data && data_at < 0)) begin
            $display("timeout in case %0s: result pulse never arrived", name);
            timeouts++;
        end else if (want_inst && want_data && inst_at >= data_at) begin
            $display("case %0s returned the data result before the fetch", name);
            errors++;
        end
    endtask

    initial begin
        int             fd;
        int             n;
        int             asserts_failed;
        string          line;
        logic [127:0]   name;
        logic [127:0]   op;
        logic [31:0]    addr;
        logic [31:0]    addr2;
        logic [31:0]    wdata;
        logic [31:0]    wmask;
        logic [31:0]    exp1;
        logic [31:0]    exp2;
        mem_req_t       req;
        errors     = 0;
        timeouts   = 0;
        rst_n      = 1'b0;
        inst_start = 1'b0;
        d_start    = 1'b0;
        i_addr     = '0;
        d_req      = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 3; i++) begin     // idle ports, no pulses
            @(negedge clk);
            check_value("reset", 32'h1, {31'b0, inst_ready && d_ready});
            check_value("reset", 32'h0, {30'b0, inst_valid, rdata_valid});
        end
        fd = $fopen("testbench/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 1 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h %h %h",
                        name, op, addr, addr2, wdata, wmask, exp1, exp2);
            if (n != 8) begin
                $display("malformed line in the cases file: %s", line);
                errors++;
                continue;
            end
            req       = '0;
            req.addr  = addr;
            req.wdata = wdata;
            req.wmask = wmask;
            wait_ready(name);
            if (op == "write") begin
                req.write = 1'b1;
                start_cmd(1'b0, 1'b1, 32'h0, req);
                wait_ready(name);
            end else if (op == "read") begin
                start_cmd(1'b0, 1'b1, 32'h0, req);
                collect_results(name, 1'b0, 1'b1, 32'h0, exp1);
            end else if (op == "fetch") begin
                start_cmd(1'b1, 1'b0, addr, req);
                collect_results(name, 1'b1, 1'b0, exp1, 32'h0);
            end else if (op == "both") begin
                req.addr = addr2;               // data read goes to the second address
                start_cmd(1'b1, 1'b1, addr, req);
                collect_results(name, 1'b1, 1'b1, exp1, exp2);
            end else begin
                $display("unknown operation in case %0s", name);
                errors++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        asserts_failed =
            mem_subsystem_top_i.mem_port_arbiter_i.mem_subsystem_asserts_i.failures;
        $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, asserts_failed);
        if (errors == 0 && timeouts == 0 && asserts_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
